/* hw/accumulator_array.sv */
`default_nettype none
`timescale 1ns/10ps

module accumulator_array (
  input  wire                     aclk,
  input  wire                     rst_n,
  input  wire logic               clken,
  input  wire logic               in_valid,
  input  wire logic               in_last,
  input  wire logic               in_first,
  input  wire conv_pkg::results_t products,
  output logic                    out_valid,
  output conv_pkg::results_t      totals
);
  import conv_pkg::*;

  results_t totals_next;

  // The first beat of a packet starts a fresh sum, so no separate clear is needed
  // between packets.
  always_comb begin
    acc_t base;
    for (int i = 0; i < PRODUCT_COUNT; i++) begin
      base = in_first ? '0 : totals[i];
      totals_next[i] = base + products[i]; // wraps at ACC_WIDTH bits.
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      totals <= '0;
    end else if (clken && in_valid) begin
      totals <= totals_next;
    end
  end

  // totals are complete only after the last beat has been added. They hold until the
  // next packet begins, which is what lets the engine stall with its output intact.
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (clken) begin
      out_valid <= in_valid & in_last;
    end
  end

endmodule

`default_nettype wire

/* hw/axis_conv_engine.sv */
`default_nettype none
`timescale 1ns/10ps

module axis_conv_engine (
  input  wire                     aclk,
  input  wire                     rst_n,
  input  wire logic               s_axis_tvalid,
  output logic                    s_axis_tready,
  input  wire logic               s_axis_tlast,
  input  wire conv_pkg::tag_t     s_axis_tuser,
  input  wire conv_pkg::pixels_t  s_axis_tdata_pixels,
  input  wire conv_pkg::weights_t s_axis_tdata_weights,
  output logic                    m_axis_tvalid,
  input  wire logic               m_axis_tready,
  output logic                    m_axis_tlast,
  output conv_pkg::results_t      m_axis_tdata,
  output conv_pkg::tag_t          m_axis_tuser
);
  import conv_pkg::*;

  logic     eng_valid;
  logic     eng_last;
  results_t eng_results;
  tag_t     eng_tag;
  logic     slice_ready;
  logic     valid_prev; // engine valid of the previous enabled cycle.
  logic     clken;

  // A full two-stage skid buffer for the wide result would double its area. The
  // engine never drives valid in two enabled cycles in a row, so in the cycle right
  // after a result was handed over it can advance even while the slice is full.
  assign clken = valid_prev | slice_ready;

  // Enabled with the engine, so a result that is stalled at the slice input does
  // not set valid_prev before the slice has taken it.
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      valid_prev <= 1'b1; // keeps s_axis_tready high out of reset.
    end else if (clken) begin
      valid_prev <= eng_valid;
    end
  end

  conv_engine u_engine (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .clken     (clken),
    .s_valid   (s_axis_tvalid),
    .s_ready   (s_axis_tready),
    .s_last    (s_axis_tlast),
    .s_tag     (s_axis_tuser),
    .s_pixels  (s_axis_tdata_pixels),
    .s_weights (s_axis_tdata_weights),
    .m_valid   (eng_valid),
    .m_last    (eng_last),
    .m_results (eng_results),
    .m_tag     (eng_tag)
  );

  axis_slice u_slice (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .s_valid   (eng_valid),
    .s_ready   (slice_ready),
    .s_last    (eng_last),
    .s_results (eng_results),
    .s_tag     (eng_tag),
    .m_valid   (m_axis_tvalid),
    .m_ready   (m_axis_tready),
    .m_last    (m_axis_tlast),
    .m_results (m_axis_tdata),
    .m_tag     (m_axis_tuser)
  );

endmodule

`default_nettype wire

/* hw/axis_slice.sv */
`default_nettype none
`timescale 1ns/10ps

module axis_slice (
  input  wire                     aclk,
  input  wire                     rst_n,
  input  wire logic               s_valid,
  output logic                    s_ready,
  input  wire logic               s_last,
  input  wire conv_pkg::results_t s_results,
  input  wire conv_pkg::tag_t     s_tag,
  output logic                    m_valid,
  input  wire logic               m_ready,
  output logic                    m_last,
  output conv_pkg::results_t      m_results,
  output conv_pkg::tag_t          m_tag
);
  import conv_pkg::*;

  logic load;

  // A single register stage. It may take a new beat when it is empty or when its
  // current beat leaves on this same edge.
  // s_ready depends combinationally on m_ready, so this stage does not cut the
  // ready path.
  assign s_ready = m_ready | ~m_valid;
  assign load    = s_ready & s_valid;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else if (s_ready) begin
      m_valid <= s_valid; // empties when drained with nothing new.
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      m_last    <= s_last;
      m_results <= s_results;
      m_tag     <= s_tag;
    end
  end

endmodule

`default_nettype wire

/* hw/conv_engine.sv */
`default_nettype none
`timescale 1ns/10ps

module conv_engine (
  input  wire                     aclk,
  input  wire                     rst_n,
  input  wire logic               clken,
  input  wire logic               s_valid,
  output logic                    s_ready,
  input  wire logic               s_last,
  input  wire conv_pkg::tag_t     s_tag,
  input  wire conv_pkg::pixels_t  s_pixels,
  input  wire conv_pkg::weights_t s_weights,
  output logic                    m_valid,
  output logic                    m_last,
  output conv_pkg::results_t      m_results,
  output conv_pkg::tag_t          m_tag
);
  import conv_pkg::*;

  logic     accept;
  logic     in_packet;  // set between the first and the last beat of a packet.
  logic     first_beat;
  tag_t     first_tag;  // tag of the packet currently being summed.
  tag_t     beat_tag;
  tag_t     tag_d1;
  tag_t     tag_d2;
  logic     mul_valid;
  logic     mul_last;
  logic     mul_first;
  results_t products;

  // The engine has no back-pressure of its own, it simply freezes with clken.
  assign s_ready    = clken;
  assign accept     = clken & s_valid;
  assign first_beat = ~in_packet;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      in_packet <= 1'b0;
    end else if (accept) begin
      in_packet <= ~s_last; // a last beat closes the packet.
    end
  end

  always_ff @(posedge aclk) begin
    if (accept && first_beat) first_tag <= s_tag;
  end

  // On the first beat the latch is not loaded yet, so the live tag is taken.
  assign beat_tag = first_beat ? s_tag : first_tag;

  // Two stages, matching the multiplier and the accumulator registers.
  always_ff @(posedge aclk) begin
    if (clken) begin
      tag_d1 <= beat_tag;
      tag_d2 <= tag_d1;
    end
  end

  multiplier_array u_multiplier (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .clken     (clken),
    .in_valid  (s_valid),
    .in_last   (s_last),
    .in_first  (first_beat),
    .pixels    (s_pixels),
    .weights   (s_weights),
    .out_valid (mul_valid),
    .out_last  (mul_last),
    .out_first (mul_first),
    .products  (products)
  );

  accumulator_array u_accumulator (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .clken     (clken),
    .in_valid  (mul_valid),
    .in_last   (mul_last),
    .in_first  (mul_first),
    .products  (products),
    .out_valid (m_valid),
    .totals    (m_results)
  );

  assign m_tag  = tag_d2;
  assign m_last = m_valid; // each result beat is a whole packet.

endmodule

`default_nettype wire

/* hw/conv_pkg.sv */
`default_nettype none

package conv_pkg;

  // beat geometry of the engine.
  localparam int COPIES  = 2; // independent pixel/weight sets per beat.
  localparam int GROUPS  = 2; // weight groups in each copy.
  localparam int MEMBERS = 2; // weights in each group.
  localparam int UNITS   = 4; // pixels per copy per beat.

  // operand and result widths.
  localparam int WORD_WIDTH    = 8;
  localparam int PRODUCT_WIDTH = 2 * WORD_WIDTH; // full width of one signed product.
  localparam int ACC_WIDTH     = 24;             // sums wrap modulo 2**ACC_WIDTH.
  localparam int TAG_WIDTH     = 4;

  // element counts of the flattened stream vectors.
  localparam int PIXEL_COUNT   = COPIES * UNITS;
  localparam int WEIGHT_COUNT  = COPIES * GROUPS * MEMBERS;
  localparam int PRODUCT_COUNT = COPIES * GROUPS * MEMBERS * UNITS;

  typedef logic [WORD_WIDTH-1:0] word_t; // one signed pixel or weight.
  typedef logic [ACC_WIDTH-1:0]  acc_t;  // one signed product or running sum.
  typedef logic [TAG_WIDTH-1:0]  tag_t;  // tuser value of a packet.

  // Unit u of copy c sits at element c*UNITS+u.
  typedef word_t [PIXEL_COUNT-1:0] pixels_t;

  // Member m of group g of copy c sits at element (c*GROUPS+g)*MEMBERS+m.
  typedef word_t [WEIGHT_COUNT-1:0] weights_t;

  // Ordered copy, group, member, unit with unit changing fastest.
  typedef acc_t [PRODUCT_COUNT-1:0] results_t;

endpackage

`default_nettype wire

/* hw/multiplier_array.sv */
`default_nettype none
`timescale 1ns/10ps

module multiplier_array (
  input  wire                     aclk,
  input  wire                     rst_n,
  input  wire logic               clken,
  input  wire logic               in_valid,
  input  wire logic               in_last,
  input  wire logic               in_first,
  input  wire conv_pkg::pixels_t  pixels,
  input  wire conv_pkg::weights_t weights,
  output logic                    out_valid,
  output logic                    out_last,
  output logic                    out_first,
  output conv_pkg::results_t      products
);
  import conv_pkg::*;

  results_t products_next;

  // Every weight of a copy meets every pixel of that same copy.
  always_comb begin
    logic signed [PRODUCT_WIDTH-1:0] prod;
    for (int c = 0; c < COPIES; c++) begin
      for (int g = 0; g < GROUPS; g++) begin
        for (int m = 0; m < MEMBERS; m++) begin
          for (int u = 0; u < UNITS; u++) begin
            prod = $signed(pixels[c*UNITS+u]) * $signed(weights[(c*GROUPS+g)*MEMBERS+m]);
            products_next[((c*GROUPS+g)*MEMBERS+m)*UNITS+u] =
              {{(ACC_WIDTH-PRODUCT_WIDTH){prod[PRODUCT_WIDTH-1]}}, prod}; // sign extend.
          end
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
      out_first <= 1'b0;
    end else if (clken) begin
      out_valid <= in_valid;
      out_last  <= in_last;
      out_first <= in_first;
    end
  end

  always_ff @(posedge aclk) begin
    if (clken) products <= products_next;
  end

endmodule

`default_nettype wire

/* src.f */
hw/conv_pkg.sv
hw/multiplier_array.sv
hw/accumulator_array.sv
hw/conv_engine.sv
hw/axis_slice.sv
hw/axis_conv_engine.sv
tb/axis_conv_engine_tb.sv

/* tb/axis_conv_engine_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module axis_conv_engine_tb;
  import conv_pkg::*;

  logic     aclk;
  logic     rst_n;
  logic     s_axis_tvalid;
  logic     s_axis_tready;
  logic     s_axis_tlast;
  tag_t     s_axis_tuser;
  pixels_t  s_axis_tdata_pixels;
  weights_t s_axis_tdata_weights;
  logic     m_axis_tvalid;
  logic     m_axis_tready;
  logic     m_axis_tlast;
  results_t m_axis_tdata;
  tag_t     m_axis_tuser;

  logic [31:0] lfsr = 32'h52ef_3572;
  logic        bp_on = 1'b0;       // random m_axis_tready when set.
  int          beats_sent = 0;
  int          cycle = 0;
  int          result_errors = 0;
  int          tag_errors = 0;
  int          last_errors = 0;
  int          flag_errors = 0;
  int          other_errors = 0;

  pixels_t  pkt_pixels[$];  // accepted beats of the packet still open.
  weights_t pkt_weights[$];
  tag_t     pkt_tag;
  results_t exp_results[$];
  tag_t     exp_tags[$];
  logic     prev_stall = 1'b0;
  results_t prev_data;
  tag_t     prev_tag;

  axis_conv_engine DUT (
    .aclk                 (aclk),
    .rst_n                (rst_n),
    .s_axis_tvalid        (s_axis_tvalid),
    .s_axis_tready        (s_axis_tready),
    .s_axis_tlast         (s_axis_tlast),
    .s_axis_tuser         (s_axis_tuser),
    .s_axis_tdata_pixels  (s_axis_tdata_pixels),
    .s_axis_tdata_weights (s_axis_tdata_weights),
    .m_axis_tvalid        (m_axis_tvalid),
    .m_axis_tready        (m_axis_tready),
    .m_axis_tlast         (m_axis_tlast),
    .m_axis_tdata         (m_axis_tdata),
    .m_axis_tuser         (m_axis_tuser)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]}; // one step per bit taken.
    end
    return r;
  endfunction

  // Sums are kept as plain integers and cut to the accumulator width at the end.
  function automatic results_t ref_results();
    int       sums [PRODUCT_COUNT];
    results_t r;
    pixels_t  px;
    weights_t wt;
    int       p;
    int       w;
    int       k;
    for (int i = 0; i < PRODUCT_COUNT; i++) sums[i] = 0;
    for (int b = 0; b < pkt_pixels.size(); b++) begin
      px = pkt_pixels[b];
      wt = pkt_weights[b];
      for (int c = 0; c < COPIES; c++) begin
        for (int g = 0; g < GROUPS; g++) begin
          for (int m = 0; m < MEMBERS; m++) begin
            w = $signed(wt[(c*GROUPS+g)*MEMBERS+m]);
            for (int u = 0; u < UNITS; u++) begin
              p = $signed(px[c*UNITS+u]);
              k = ((c*GROUPS+g)*MEMBERS+m)*UNITS+u;
              sums[k] += p * w;
            end
          end
        end
      end
    end
    for (int i = 0; i < PRODUCT_COUNT; i++) r[i] = acc_t'(sums[i]);
    return r;
  endfunction

  task automatic compare_results(input string name, input results_t exp, input results_t act);
    if (act !== exp) begin
      result_errors++;
      for (int i = 0; i < PRODUCT_COUNT; i++) begin
        if (act[i] !== exp[i])
          $display("[ERROR] %s[%0d] expected %h got %h", name, i, exp[i], act[i]);
      end
    end
  endtask

  task automatic compare_tag(input string name, input tag_t exp, input tag_t act);
    if (act !== exp) begin
      tag_errors++;
      $display("[ERROR] %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic compare_last(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      last_errors++;
      $display("[ERROR] %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errors++;
      $display("[ERROR] %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic finish_run();
    int total;
    total = result_errors + tag_errors + last_errors + flag_errors + other_errors;
    $display("errors: results %0d, tag %0d, last %0d, control %0d, other %0d",
             result_errors, tag_errors, last_errors, flag_errors, other_errors);
    if (total == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  endtask

  // hs is sampled at the edge itself, before the registers move.
  task automatic tick(output logic hs);
    @(posedge aclk);
    hs = s_axis_tvalid && s_axis_tready;
    #1;
    if (bp_on) m_axis_tready = (rand_bits(2) != 0); // ready about three cycles in four.
    else m_axis_tready = 1'b1;
  endtask

  task automatic idle(input int n);
    logic hs;
    repeat (n) tick(hs);
  endtask

  task automatic apply_reset();
    logic hs;
    rst_n = 1'b0;
    s_axis_tvalid = 1'b0;
    repeat (16) tick(hs);
    rst_n = 1'b1;
    pkt_pixels.delete(); // a packet cut by reset is forgotten.
    pkt_weights.delete();
    compare_flag("m_axis_tvalid", 1'b0, m_axis_tvalid);
    compare_flag("s_axis_tready", 1'b1, s_axis_tready);
  endtask

  task automatic send_beat(input logic last, input tag_t tag, input pixels_t px,
                           input weights_t wt);
    logic hs;
    s_axis_tvalid        = 1'b1;
    s_axis_tlast         = last;
    s_axis_tuser         = tag;
    s_axis_tdata_pixels  = px;
    s_axis_tdata_weights = wt;
    do begin
      tick(hs);
    end while (!hs);
    s_axis_tvalid = 1'b0;
    beats_sent++;
    if (pkt_pixels.size() == 0) pkt_tag = tag; // the packet is named by its first beat.
    pkt_pixels.push_back(px);
    pkt_weights.push_back(wt);
    if (last) begin
      exp_results.push_back(ref_results());
      exp_tags.push_back(pkt_tag);
      pkt_pixels.delete();
      pkt_weights.delete();
    end
  endtask

  task automatic send_random_packet();
    int       len;
    pixels_t  px;
    weights_t wt;
    len = 2 + rand_bits(3);
    for (int b = 0; b < len; b++) begin
      if (rand_bits(2) == 0) idle(1 + rand_bits(2));
      for (int i = 0; i < PIXEL_COUNT; i++) px[i] = word_t'(rand_bits(WORD_WIDTH));
      for (int i = 0; i < WEIGHT_COUNT; i++) wt[i] = word_t'(rand_bits(WORD_WIDTH));
      send_beat(b == len - 1, tag_t'(rand_bits(TAG_WIDTH)), px, wt);
    end
  endtask

  // Nine beats of the same operand pair, with a new tag on every beat.
  task automatic send_extreme_packet(input word_t p, input word_t w);
    pixels_t  px;
    weights_t wt;
    for (int i = 0; i < PIXEL_COUNT; i++) px[i] = p;
    for (int i = 0; i < WEIGHT_COUNT; i++) wt[i] = w;
    for (int b = 0; b < 9; b++) send_beat(b == 8, tag_t'(b + 5), px, wt);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_results.size() != 0 && n < 100) begin
      idle(1);
      n++;
    end
    idle(8); // room for a stray extra beat to show up.
  endtask

  always @(posedge aclk) begin
    if (!rst_n) begin
      prev_stall = 1'b0;
    end else begin
      if (prev_stall) begin
        if (!m_axis_tvalid) begin
          other_errors++;
          $display("m_axis_tvalid dropped before the stalled result was taken");
        end else begin
          compare_results("m_axis_tdata", prev_data, m_axis_tdata); // held under stall.
          compare_tag("m_axis_tuser", prev_tag, m_axis_tuser);
        end
      end
      if (m_axis_tvalid && m_axis_tready) begin
        if (exp_results.size() == 0) begin
          other_errors++;
          $display("a result beat arrived while no packet was outstanding");
        end else begin
          compare_results("m_axis_tdata", exp_results.pop_front(), m_axis_tdata);
          compare_tag("m_axis_tuser", exp_tags.pop_front(), m_axis_tuser);
          compare_last("m_axis_tlast", 1'b1, m_axis_tlast);
        end
      end
      prev_stall = m_axis_tvalid && !m_axis_tready;
      prev_data  = m_axis_tdata;
      prev_tag   = m_axis_tuser;
    end
  end

  always @(posedge aclk) begin
    cycle++;
    if (cycle > 40 * beats_sent + 200) begin
      other_errors++;
      $display("timeout after %0d cycles with %0d beats sent", cycle, beats_sent);
      finish_run();
    end
  end

  initial begin
    int       lat;
    pixels_t  px;
    weights_t wt;
    results_t hand;
    logic     hs;
    rst_n = 1'b0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
    s_axis_tuser = '0;
    s_axis_tdata_pixels = '0;
    s_axis_tdata_weights = '0;
    m_axis_tready = 1'b1;
    apply_reset();

    // Pixels 1..8 against unit weights, then unit pixels against weights -1..-8.
    for (int i = 0; i < PIXEL_COUNT; i++) px[i] = word_t'(i + 1);
    for (int i = 0; i < WEIGHT_COUNT; i++) wt[i] = 8'd1;
    send_beat(1'b0, 4'ha, px, wt);
    for (int i = 0; i < PIXEL_COUNT; i++) px[i] = 8'd1;
    for (int i = 0; i < WEIGHT_COUNT; i++) wt[i] = word_t'(-(i + 1));
    send_beat(1'b1, 4'h3, px, wt);
    for (int c = 0; c < COPIES; c++)
      for (int g = 0; g < GROUPS; g++)
        for (int m = 0; m < MEMBERS; m++)
          for (int u = 0; u < UNITS; u++)
            hand[((c*GROUPS+g)*MEMBERS+m)*UNITS+u] =
              acc_t'((c*UNITS+u+1) - ((c*GROUPS+g)*MEMBERS+m+1));
    exp_results[exp_results.size()-1] = hand;

    // Count edges from the accepting edge up to and including the one that
    // raises m_axis_tvalid.
    lat = 1; // the accepting edge is the first one counted.
    do begin
      tick(hs);
      lat++;
    end while (!m_axis_tvalid && lat < 10);
    if (lat != 3) begin
      other_errors++;
      $display("[ERROR] m_axis_tvalid latency expected %h got %h", 3, lat);
    end

    repeat (25) send_random_packet();
    bp_on = 1'b1;
    repeat (25) send_random_packet();
    bp_on = 1'b0;

    send_extreme_packet(8'h80, 8'h80);
    send_extreme_packet(8'h7f, 8'h80);

    // Reset in the middle of a packet, then check that nothing of it survives.
    drain();
    for (int b = 0; b < 3; b++) begin
      for (int i = 0; i < PIXEL_COUNT; i++) px[i] = word_t'(rand_bits(WORD_WIDTH));
      for (int i = 0; i < WEIGHT_COUNT; i++) wt[i] = word_t'(rand_bits(WORD_WIDTH));
      send_beat(1'b0, 4'h9, px, wt);
    end
    apply_reset();
    send_random_packet();
    drain();

    if (exp_results.size() != 0) begin
      other_errors++;
      $display("%0d expected result beats never arrived", exp_results.size());
    end
    finish_run();
  end

endmodule

`default_nettype wire
